/* src/vga_macros.svh */
/*
 * 800x600 at 60 Hz frame timing, text rectangle geometry,
 * colour constants and the overlay lookup latency
 */
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// horizontal timing, in pixels
`define H_VISIBLE 800
`define H_FRONT   40
`define H_SYNC    128
`define H_TOTAL   1056

// vertical timing, in lines
`define V_VISIBLE 600
`define V_FRONT   1
`define V_SYNC    4
`define V_TOTAL   628

// text rectangle, 16 cells by 1.25 rows
`define RECT_X 483
`define RECT_Y 30
`define RECT_W 128
`define RECT_H 20

`define COL_BLACK    12'h000
`define COL_BORDER   12'hfff
`define COL_STRIPE_A 12'h115
`define COL_STRIPE_B 12'h226
`define COL_TEXT     12'h8f8
`define COL_TEXT_BG  12'h115

`define OVERLAY_FETCH_DELAY 2 // text buffer + font rom

`endif

/* src/vga_pkg.sv */
/*
 * shared types for the display pipeline:
 * coordinates, colour, character code, glyph row, text cell address
 */
package vga_pkg;

  typedef logic [10:0] coord_t;     // pixel or line counter
  typedef logic [11:0] rgb_t;       // 4-4-4 colour

  typedef logic [7:0] char_code_t;

  // leftmost pixel in bit 7
  typedef logic [7:0] font_row_t;

  // {row[3:0], column[3:0]}
  typedef logic [7:0] char_xy_t;

endpackage

/* src/vga_timing.sv */
/*
 * vga_timing: free-running 800x600 counters,
 * registered sync and blanking decode
 */
`timescale 1ns/1ps
`include "vga_macros.svh"

module vga_timing (
  input  logic            pclk,
  input  logic            rst,
  output vga_pkg::coord_t hcount,
  output vga_pkg::coord_t vcount,
  output logic            hsync,
  output logic            vsync,
  output logic            hblnk,
  output logic            vblnk
);

  vga_pkg::coord_t hcount_nxt;
  vga_pkg::coord_t vcount_nxt;
  logic            hsync_nxt;
  logic            vsync_nxt;
  logic            hblnk_nxt;
  logic            vblnk_nxt;

  always_comb begin
    if (hcount == vga_pkg::coord_t'(`H_TOTAL - 1)) begin
      hcount_nxt = '0;
      if (vcount == vga_pkg::coord_t'(`V_TOTAL - 1)) begin
        vcount_nxt = '0;
      end else begin
        vcount_nxt = vcount + 11'd1;
      end
    end else begin
      hcount_nxt = hcount + 11'd1;
      vcount_nxt = vcount; // line holds until hcount wraps
    end
  end

  // decode from the next values so the flags land with the counters
  assign hblnk_nxt = (hcount_nxt >= vga_pkg::coord_t'(`H_VISIBLE));
  assign vblnk_nxt = (vcount_nxt >= vga_pkg::coord_t'(`V_VISIBLE));

  assign hsync_nxt = (hcount_nxt >= vga_pkg::coord_t'(`H_VISIBLE + `H_FRONT)) &&
                     (hcount_nxt <  vga_pkg::coord_t'(`H_VISIBLE + `H_FRONT + `H_SYNC));
  assign vsync_nxt = (vcount_nxt >= vga_pkg::coord_t'(`V_VISIBLE + `V_FRONT)) &&
                     (vcount_nxt <  vga_pkg::coord_t'(`V_VISIBLE + `V_FRONT + `V_SYNC));

  always_ff @(posedge pclk) begin
    if (rst) begin
      hcount <= '0;
      vcount <= '0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      hblnk  <= 1'b0;
      vblnk  <= 1'b0;
    end else begin
      hcount <= hcount_nxt;
      vcount <= vcount_nxt;
      hsync  <= hsync_nxt;  // active high
      vsync  <= vsync_nxt;
      hblnk  <= hblnk_nxt;
      vblnk  <= vblnk_nxt;
    end
  end

endmodule

/* src/signal_delay.sv */
/*
 * signal_delay: DEPTH-stage register chain
 * for a WIDTH-bit bundle, cleared by reset
 */
`timescale 1ns/1ps

module signal_delay #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  logic             pclk,
  input  logic             rst,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  logic [WIDTH-1:0] stage [DEPTH];

  always_ff @(posedge pclk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1]; // shift toward dout
      end
    end
  end

  assign dout = stage[DEPTH-1];

endmodule

/* src/draw_background.sv */
/*
 * draw_background: white border, two-tone vertical stripes,
 * black in blanking; one register stage
 */
`timescale 1ns/1ps
`include "vga_macros.svh"

module draw_background (
  input  logic            pclk,
  input  logic            rst,
  input  vga_pkg::coord_t hcount_in,
  input  vga_pkg::coord_t vcount_in,
  input  logic            hsync_in,
  input  logic            vsync_in,
  input  logic            hblnk_in,
  input  logic            vblnk_in,
  output vga_pkg::coord_t hcount_out,
  output vga_pkg::coord_t vcount_out,
  output logic            hsync_out,
  output logic            vsync_out,
  output logic            hblnk_out,
  output logic            vblnk_out,
  output vga_pkg::rgb_t   rgb_out
);

  vga_pkg::rgb_t rgb_nxt;
  logic          on_border;

  assign on_border = (hcount_in == 11'd0) ||
                     (hcount_in == vga_pkg::coord_t'(`H_VISIBLE - 1)) ||
                     (vcount_in == 11'd0) ||
                     (vcount_in == vga_pkg::coord_t'(`V_VISIBLE - 1));

  always_comb begin
    if (hblnk_in || vblnk_in) begin
      rgb_nxt = `COL_BLACK;
    end else if (on_border) begin
      rgb_nxt = `COL_BORDER;
    end else begin
      rgb_nxt = hcount_in[5] ? `COL_STRIPE_B : `COL_STRIPE_A; // 32 px stripes
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      hcount_out <= '0;
      vcount_out <= '0;
      hsync_out  <= 1'b0;
      vsync_out  <= 1'b0;
      hblnk_out  <= 1'b0;
      vblnk_out  <= 1'b0;
      rgb_out    <= '0;
    end else begin
      hcount_out <= hcount_in;
      vcount_out <= vcount_in;
      hsync_out  <= hsync_in;
      vsync_out  <= vsync_in;
      hblnk_out  <= hblnk_in;
      vblnk_out  <= vblnk_in;
      rgb_out    <= rgb_nxt;
    end
  end

endmodule

/* src/text_buffer.sv */
/*
 * text_buffer: fixed message ROM, one character per text cell,
 * registered read
 */
`timescale 1ns/1ps

module text_buffer (
  input  logic                pclk,
  input  vga_pkg::char_xy_t   char_xy,
  output vga_pkg::char_code_t char_code
);

  always_ff @(posedge pclk) begin
    case (char_xy)
      // row 0
      8'h00: char_code <= "V";
      8'h01: char_code <= "G";
      8'h02: char_code <= "A";
      8'h03: char_code <= " ";
      8'h04: char_code <= "T";
      8'h05: char_code <= "E";
      8'h06: char_code <= "X";
      8'h07: char_code <= "T";
      8'h08: char_code <= " ";
      8'h09: char_code <= "O";
      8'h0a: char_code <= "V";
      8'h0b: char_code <= "E";
      8'h0c: char_code <= "R";
      8'h0d: char_code <= "L";
      8'h0e: char_code <= "A";
      8'h0f: char_code <= "Y";
      // row 1, only its top 4 lines are shown
      8'h10: char_code <= "0";
      8'h11: char_code <= "1";
      8'h12: char_code <= "2";
      8'h13: char_code <= "3";
      8'h14: char_code <= "4";
      8'h15: char_code <= "5";
      8'h16: char_code <= "6";
      8'h17: char_code <= "7";
      8'h18: char_code <= "8";
      8'h19: char_code <= "9";
      8'h1a: char_code <= "A";
      8'h1b: char_code <= "B";
      8'h1c: char_code <= "C";
      8'h1d: char_code <= "D";
      8'h1e: char_code <= "E";
      8'h1f: char_code <= "F";
      default: char_code <= " ";
    endcase
  end

endmodule

/* src/font_rom.sv */
/*
 * font_rom: 8x16 glyphs for space, 0-9 and A-Y,
 * registered row read, top line in the upper byte
 */
`timescale 1ns/1ps

module font_rom (
  input  logic                pclk,
  input  vga_pkg::char_code_t char_code,
  input  logic [3:0]          char_line,
  output vga_pkg::font_row_t  char_pixels
);

  logic [127:0] glyph; // 16 rows, line 0 in bits 127:120

  always_comb begin
    case (char_code)
      8'h20: glyph = 128'h0000_0000_0000_0000_0000_0000_0000_0000; // space
      8'h30: glyph = 128'h0000_7cc6_c6ce_def6_e6c6_c67c_0000_0000;
      8'h31: glyph = 128'h0000_1838_7818_1818_1818_187e_0000_0000;
      8'h32: glyph = 128'h0000_7cc6_060c_1830_60c0_c6fe_0000_0000;
      8'h33: glyph = 128'h0000_7cc6_0606_3c06_0606_c67c_0000_0000;
      8'h34: glyph = 128'h0000_0c1c_3c6c_ccfe_0c0c_0c1e_0000_0000;
      8'h35: glyph = 128'h0000_fec0_c0c0_fc06_0606_c67c_0000_0000;
      8'h36: glyph = 128'h0000_3860_c0c0_fcc6_c6c6_c67c_0000_0000;
      8'h37: glyph = 128'h0000_fec6_0606_0c18_3030_3030_0000_0000;
      8'h38: glyph = 128'h0000_7cc6_c6c6_7cc6_c6c6_c67c_0000_0000;
      8'h39: glyph = 128'h0000_7cc6_c6c6_7e06_0606_0c78_0000_0000;
      8'h41: glyph = 128'h0000_1038_6cc6_c6fe_c6c6_c6c6_0000_0000; // A
      8'h42: glyph = 128'h0000_fc66_6666_7c66_6666_66fc_0000_0000;
      8'h43: glyph = 128'h0000_3c66_c2c0_c0c0_c0c2_663c_0000_0000;
      8'h44: glyph = 128'h0000_f86c_6666_6666_6666_6cf8_0000_0000;
      8'h45: glyph = 128'h0000_fe66_6268_7868_6062_66fe_0000_0000;
      8'h46: glyph = 128'h0000_fe66_6268_7868_6060_60f0_0000_0000;
      8'h47: glyph = 128'h0000_3c66_c2c0_c0de_c6c6_663a_0000_0000;
      8'h48: glyph = 128'h0000_c6c6_c6c6_fec6_c6c6_c6c6_0000_0000;
      8'h49: glyph = 128'h0000_3c18_1818_1818_1818_183c_0000_0000;
      8'h4a: glyph = 128'h0000_1e0c_0c0c_0c0c_cccc_cc78_0000_0000;
      8'h4b: glyph = 128'h0000_e666_666c_7878_6c66_66e6_0000_0000;
      8'h4c: glyph = 128'h0000_f060_6060_6060_6062_66fe_0000_0000;
      8'h4d: glyph = 128'h0000_c6ee_fefe_d6c6_c6c6_c6c6_0000_0000;
      8'h4e: glyph = 128'h0000_c6e6_f6fe_dece_c6c6_c6c6_0000_0000;
      8'h4f: glyph = 128'h0000_7cc6_c6c6_c6c6_c6c6_c67c_0000_0000;
      8'h50: glyph = 128'h0000_fc66_6666_7c60_6060_60f0_0000_0000;
      8'h51: glyph = 128'h0000_7cc6_c6c6_c6c6_c6d6_de7c_0c0e_0000; // tail below
      8'h52: glyph = 128'h0000_fc66_6666_7c6c_6666_66e6_0000_0000;
      8'h53: glyph = 128'h0000_7cc6_c660_380c_06c6_c67c_0000_0000;
      8'h54: glyph = 128'h0000_7e7e_5a18_1818_1818_183c_0000_0000;
      8'h55: glyph = 128'h0000_c6c6_c6c6_c6c6_c6c6_c67c_0000_0000;
      8'h56: glyph = 128'h0000_c6c6_c6c6_c6c6_c66c_3810_0000_0000;
      8'h57: glyph = 128'h0000_c6c6_c6c6_d6d6_d6fe_ee6c_0000_0000;
      8'h58: glyph = 128'h0000_c6c6_6c7c_3838_7c6c_c6c6_0000_0000;
      8'h59: glyph = 128'h0000_6666_6666_3c18_1818_183c_0000_0000; // Y
      default: glyph = '0; // unsupported code, blank cell
    endcase
  end

  // ~char_line is 15 - line, so line 0 picks the top byte
  always_ff @(posedge pclk) begin
    char_pixels <= glyph[{~char_line, 3'b000} +: 8];
  end

endmodule

/* src/draw_rect_char.sv */
/*
 * draw_rect_char: text overlay on a fixed rectangle,
 * cell/line lookup, 2-cycle fetch alignment, output register
 */
`timescale 1ns/1ps
`include "vga_macros.svh"

module draw_rect_char (
  input  logic               pclk,
  input  logic               rst,
  input  vga_pkg::coord_t    hcount_in,
  input  vga_pkg::coord_t    vcount_in,
  input  logic               hsync_in,
  input  logic               vsync_in,
  input  logic               hblnk_in,
  input  logic               vblnk_in,
  input  vga_pkg::rgb_t      rgb_in,
  input  vga_pkg::font_row_t char_pixels,
  output vga_pkg::coord_t    hcount_out,
  output vga_pkg::coord_t    vcount_out,
  output logic               hsync_out,
  output logic               vsync_out,
  output logic               hblnk_out,
  output logic               vblnk_out,
  output vga_pkg::rgb_t      rgb_out,
  output vga_pkg::char_xy_t  char_xy,
  output logic [3:0]         char_line
);

  localparam int DLY_W = 2 * $bits(vga_pkg::coord_t) + 4 + $bits(vga_pkg::rgb_t);

  vga_pkg::coord_t rel_x;
  vga_pkg::coord_t rel_y;
  vga_pkg::coord_t hcount_d;
  vga_pkg::coord_t vcount_d;
  vga_pkg::coord_t rel_x_d;
  logic            hsync_d;
  logic            vsync_d;
  logic            hblnk_d;
  logic            vblnk_d;
  vga_pkg::rgb_t   rgb_d;
  vga_pkg::rgb_t   rgb_nxt;
  logic            in_rect;

  // position inside the rectangle, garbage outside it
  assign rel_x   = hcount_in - vga_pkg::coord_t'(`RECT_X);
  assign rel_y   = vcount_in - vga_pkg::coord_t'(`RECT_Y);
  assign char_xy = {rel_y[7:4], rel_x[6:3]}; // 8x16 px cells

  // line meets char_code at the font rom one cycle later
  always_ff @(posedge pclk) begin
    char_line <= rel_y[3:0];
  end

  signal_delay #(
    .WIDTH(DLY_W),
    .DEPTH(`OVERLAY_FETCH_DELAY)
  ) timing_dly_i (
    .pclk(pclk),
    .rst (rst),
    .din ({hcount_in, vcount_in, hsync_in, vsync_in, hblnk_in, vblnk_in, rgb_in}),
    .dout({hcount_d, vcount_d, hsync_d, vsync_d, hblnk_d, vblnk_d, rgb_d})
  );

  assign rel_x_d = hcount_d - vga_pkg::coord_t'(`RECT_X);

  assign in_rect = (hcount_d >= vga_pkg::coord_t'(`RECT_X)) &&
                   (hcount_d <  vga_pkg::coord_t'(`RECT_X + `RECT_W)) &&
                   (vcount_d >= vga_pkg::coord_t'(`RECT_Y)) &&
                   (vcount_d <  vga_pkg::coord_t'(`RECT_Y + `RECT_H));

  always_comb begin
    if (in_rect && !hblnk_d && !vblnk_d) begin
      // bit 7 is the leftmost pixel of the cell
      rgb_nxt = char_pixels[~rel_x_d[2:0]] ? `COL_TEXT : `COL_TEXT_BG;
    end else begin
      rgb_nxt = rgb_d; // background through
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      hcount_out <= '0;
      vcount_out <= '0;
      hsync_out  <= 1'b0;
      vsync_out  <= 1'b0;
      hblnk_out  <= 1'b0;
      vblnk_out  <= 1'b0;
      rgb_out    <= '0;
    end else begin
      hcount_out <= hcount_d;
      vcount_out <= vcount_d;
      hsync_out  <= hsync_d;
      vsync_out  <= vsync_d;
      hblnk_out  <= hblnk_d;
      vblnk_out  <= vblnk_d;
      rgb_out    <= rgb_nxt;
    end
  end

endmodule

/* src/vga_top.sv */
/*
 * vga_top: timing generator, background, text overlay,
 * text buffer and font ROM wired into one pipeline
 */
`timescale 1ns/1ps

module vga_top (
  input  logic            pclk,
  input  logic            rst,
  output vga_pkg::coord_t hcount,
  output vga_pkg::coord_t vcount,
  output logic            hsync,
  output logic            vsync,
  output logic            hblnk,
  output logic            vblnk,
  output vga_pkg::rgb_t   rgb
);

  vga_pkg::coord_t     tim_hcount;
  vga_pkg::coord_t     tim_vcount;
  logic                tim_hsync;
  logic                tim_vsync;
  logic                tim_hblnk;
  logic                tim_vblnk;
  vga_pkg::coord_t     bg_hcount;
  vga_pkg::coord_t     bg_vcount;
  logic                bg_hsync;
  logic                bg_vsync;
  logic                bg_hblnk;
  logic                bg_vblnk;
  vga_pkg::rgb_t       bg_rgb;
  vga_pkg::char_xy_t   char_xy;
  vga_pkg::char_code_t char_code;
  logic [3:0]          char_line;
  vga_pkg::font_row_t  char_pixels;

  vga_timing timing_i (
    .pclk(pclk), .rst(rst),
    .hcount(tim_hcount), .vcount(tim_vcount),
    .hsync(tim_hsync), .vsync(tim_vsync),
    .hblnk(tim_hblnk), .vblnk(tim_vblnk)
  );

  draw_background background_i (
    .pclk(pclk), .rst(rst),
    .hcount_in(tim_hcount), .vcount_in(tim_vcount),
    .hsync_in(tim_hsync), .vsync_in(tim_vsync),
    .hblnk_in(tim_hblnk), .vblnk_in(tim_vblnk),
    .hcount_out(bg_hcount), .vcount_out(bg_vcount),
    .hsync_out(bg_hsync), .vsync_out(bg_vsync),
    .hblnk_out(bg_hblnk), .vblnk_out(bg_vblnk),
    .rgb_out(bg_rgb)
  );

  draw_rect_char overlay_i (
    .pclk(pclk), .rst(rst),
    .hcount_in(bg_hcount), .vcount_in(bg_vcount),
    .hsync_in(bg_hsync), .vsync_in(bg_vsync),
    .hblnk_in(bg_hblnk), .vblnk_in(bg_vblnk),
    .rgb_in(bg_rgb), .char_pixels(char_pixels),
    .hcount_out(hcount), .vcount_out(vcount),
    .hsync_out(hsync), .vsync_out(vsync),
    .hblnk_out(hblnk), .vblnk_out(vblnk),
    .rgb_out(rgb), .char_xy(char_xy), .char_line(char_line)
  );

  text_buffer text_i (.pclk(pclk), .char_xy(char_xy), .char_code(char_code));

  font_rom font_i (
    .pclk(pclk), .char_code(char_code),
    .char_line(char_line), .char_pixels(char_pixels)
  );

endmodule

/* sim/vga_top_tb.sv */
/*
 * testbench for vga_top: clock, reset, trace loader,
 * per-cycle coordinate and blanking model, trace checks, watchdog
 */
`timescale 1ns/1ps
`include "vga_macros.svh"

module vga_top_tb;

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 10;
  localparam int LATENCY    = 4; // timing to output pins

  logic            pclk;
  logic            rst;
  vga_pkg::coord_t hcount;
  vga_pkg::coord_t vcount;
  logic            hsync;
  logic            vsync;
  logic            hblnk;
  logic            vblnk;
  vga_pkg::rgb_t   rgb;

  int              tr_frame[$];
  vga_pkg::coord_t tr_x[$];
  vga_pkg::coord_t tr_y[$];
  vga_pkg::rgb_t   tr_rgb[$];
  logic            tr_hs[$];
  logic            tr_vs[$];
  logic            trace_loaded = 1'b0;
  int              idx = 0; // next trace entry

  vga_top dut_i (
    .pclk(pclk), .rst(rst),
    .hcount(hcount), .vcount(vcount),
    .hsync(hsync), .vsync(vsync),
    .hblnk(hblnk), .vblnk(vblnk),
    .rgb(rgb)
  );

  initial begin
    pclk = 1'b0;
    forever #(CLK_PERIOD / 2) pclk = ~pclk;
  end

  task automatic report_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("ERR %s: got %h, expected %h at frame pixel %0d,%0d",
             name, got, exp, hcount, vcount);
    $display("sim failed");
    $fatal(1, "mismatch on %s", name);
  endtask

  task automatic check_rgb(input string name, input vga_pkg::rgb_t got, input vga_pkg::rgb_t exp);
    if (got !== exp) begin
      report_error(name, 32'(got), 32'(exp));
    end
  endtask

  task automatic check_sync(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_error(name, 32'(got), 32'(exp));
    end
  endtask

  task automatic check_coord(input string name, input vga_pkg::coord_t got,
                             input vga_pkg::coord_t exp);
    if (got !== exp) begin
      report_error(name, 32'(got), 32'(exp));
    end
  endtask

  // every output still holds its reset value
  task automatic check_all_zero();
    check_coord("hcount", hcount, '0);
    check_coord("vcount", vcount, '0);
    check_sync("hsync", hsync, 1'b0);
    check_sync("vsync", vsync, 1'b0);
    check_sync("hblnk", hblnk, 1'b0);
    check_sync("vblnk", vblnk, 1'b0);
    check_rgb("rgb", rgb, '0);
  endtask

  task automatic load_trace();
    int    fd;
    int    n;
    int    fr, x, y, c, hs, vs;
    string line;
    fd = $fopen("sim/vga_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file sim/vga_trace.txt");
      $display("sim failed");
      $fatal(1, "no trace");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%d %h %h %h %h %h", fr, x, y, c, hs, vs); // header lines give 0
        if (n == 6) begin
          tr_frame.push_back(fr);
          tr_x.push_back(vga_pkg::coord_t'(x));
          tr_y.push_back(vga_pkg::coord_t'(y));
          tr_rgb.push_back(vga_pkg::rgb_t'(c));
          tr_hs.push_back(hs[0]);
          tr_vs.push_back(vs[0]);
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    vga_pkg::coord_t mh;
    vga_pkg::coord_t mv;
    int              frame;
    int              k;
    rst = 1'b1;
    load_trace();
    if (tr_x.size() == 0) begin
      $display("the trace file holds no entries");
      $display("sim failed");
      $fatal(1, "empty trace");
    end else begin
      trace_loaded = 1'b1;
      repeat (RST_CYCLES) begin
        @(posedge pclk);
        #1;
        check_all_zero();
      end
      rst = 1'b0;
      // pipeline still flushing reset values
      for (k = 1; k < LATENCY; k++) begin
        @(posedge pclk);
        #1;
        check_all_zero();
      end
      mh = '0;
      mv = '0;
      frame = 0;
      while (idx < tr_x.size()) begin
        @(posedge pclk);
        #1;
        check_coord("hcount", hcount, mh);
        check_coord("vcount", vcount, mv);
        check_sync("hblnk", hblnk, mh >= vga_pkg::coord_t'(`H_VISIBLE));
        check_sync("vblnk", vblnk, mv >= vga_pkg::coord_t'(`V_VISIBLE));
        if (frame == tr_frame[idx] && mh == tr_x[idx] && mv == tr_y[idx]) begin
          check_rgb("rgb", rgb, tr_rgb[idx]);
          check_sync("hsync", hsync, tr_hs[idx]);
          check_sync("vsync", vsync, tr_vs[idx]);
          idx++;
        end
        if (mh == vga_pkg::coord_t'(`H_TOTAL - 1)) begin
          mh = '0;
          if (mv == vga_pkg::coord_t'(`V_TOTAL - 1)) begin
            mv = '0;
            frame++; // new frame
          end else begin
            mv = mv + 11'd1;
          end
        end else begin
          mh = mh + 11'd1;
        end
      end
      $display("sim passed");
      $finish;
    end
  end

  // traced frames plus one spare
  initial begin
    longint limit;
    wait (trace_loaded);
    limit = longint'(RST_CYCLES + LATENCY) +
            longint'(tr_frame[tr_frame.size() - 1] + 2) * `H_TOTAL * `V_TOTAL;
    #(limit * longint'(CLK_PERIOD));
    $display("timeout: the trace did not complete, %0d of %0d entries seen", idx, tr_x.size());
    $display("sim failed");
    $fatal(1, "watchdog");
  end

endmodule

/* sim/vga_trace.txt */
# frame (dec)  x  y  rgb  hsync  vsync (hex), in display order
# expected colour and sync levels of the output pixel at x,y
0 000 000 fff 0 0
0 31f 000 fff 0 0
0 320 000 000 0 0
0 347 000 000 0 0
0 348 000 000 1 0
0 3c7 000 000 1 0
0 3c8 000 000 0 0
0 00a 005 115 0 0
0 028 005 226 0 0
0 1e3 01d 226 0 0
0 1e3 020 8f8 0 0
0 1e5 020 115 0 0
0 263 020 226 0 0
0 1ed 025 115 0 0
0 1ee 025 8f8 0 0
0 25e 025 8f8 0 0
0 213 026 115 0 0
0 214 026 8f8 0 0
0 1fe 028 115 0 0
0 230 02e 115 0 0
0 1e4 030 8f8 0 0
0 261 030 8f8 0 0
0 262 030 115 0 0
0 223 031 8f8 0 0
0 1f4 032 226 0 0
0 190 257 fff 0 0
0 190 258 000 0 0
0 000 259 000 0 1
0 384 25a 000 1 1
0 000 25c 000 0 1
0 000 25d 000 0 0
0 41f 273 000 0 0
1 000 000 fff 0 0
1 1e3 020 8f8 0 0
1 25e 025 8f8 0 0

/* verilog.f */
+incdir+src
src/vga_pkg.sv
src/vga_timing.sv
src/signal_delay.sv
src/draw_background.sv
src/text_buffer.sv
src/font_rom.sv
src/draw_rect_char.sv
src/vga_top.sv
sim/vga_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the VGA pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timescale 1ns/1ps -j 0 -f verilog.f \
  --top-module vga_top_tb --Mdir obj_dir -o vga_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/vga_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -qx "sim passed" "$log"; then
  exit 0
else
  exit 1
fi
